/* verilog/audio_config.svh */
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

// mic clock period in clk_m cycles, even so the duty stays at 50%
`define AUDIO_PDM_PERIOD 32

// pdm ticks the filters are held cleared after enable
`define AUDIO_WARMUP_TICKS 64

// decimation factor per fir stage
`define AUDIO_DEC1 2
`define AUDIO_DEC2 2
`define AUDIO_DEC3 4 // total 2*2*4 = 16 ticks per pcm sample

// tone phase step per output sample
`define AUDIO_TONE_STEP 8'd12

`endif

/* verilog/audio_pkg.sv */
package audio_pkg;

  // pcm sample between decimator stages and at the top output
  typedef logic signed [15:0] pcm_t;

  // playback level into the sigma-delta stage
  typedef logic signed [7:0] level_t;

  // playback source select
  typedef enum logic [1:0] {
    src_mic_pcm = 2'd0, // decimated microphone pcm
    src_tone    = 2'd1, // triangle test tone
    src_mic_raw = 2'd2, // last raw mic bit as +/-64
    src_mute    = 2'd3
  } src_mode_t;

  // sequencer states
  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_warmup = 2'd1,
    st_run    = 2'd2
  } ctrl_state_t;

  // mic bit 1 maps to +64, bit 0 to -64
  localparam pcm_t pdm_one_level = 16'sd64;

endpackage

/* verilog/audio_ctrl_if.sv */
`timescale 1ns/100ps

// control bundle from the sequencer to the data path
interface audio_ctrl_if import audio_pkg::*; ();

  logic      clear;    // hold filters, tone phase and modulator at zero
  logic      run;      // data path live
  src_mode_t src_mode; // latched playback source
  logic [2:0] vol;     // latched volume, 7 is loudest

  modport ctrl (
    output clear,
    output run,
    output src_mode,
    output vol
  );

  modport dp (
    input clear,
    input run,
    input src_mode,
    input vol
  );

endinterface

/* verilog/pdm_clock_gen.sv */
`timescale 1ns/100ps
`include "audio_config.svh"

module pdm_clock_gen #(
  parameter int PERIOD = `AUDIO_PDM_PERIOD
) (
  input  logic clk_m,
  input  logic rst_n,
  input  logic active,   // warm-up or run
  output logic mic_clk,  // microphone bit clock
  output logic pdm_tick  // one-cycle strobe, once per mic_clk period
);

  localparam int CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

  logic [CNT_W-1:0] cnt; // position inside the mic_clk period

  // period counter, parked at 0 while idle
  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!active) begin
      cnt <= '0;
    end else if (cnt == CNT_W'(PERIOD - 1)) begin
      cnt <= '0; // wrap
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // high for the first half of the period, low while idle
  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      mic_clk <= 1'b0;
    end else begin
      mic_clk <= active && (cnt < CNT_W'(PERIOD / 2));
    end
  end

  assign pdm_tick = active && (cnt == '0); // start of each period

  // ticks are a full period apart, never back to back
  a_tick_spacing : assert property (@(posedge clk_m) disable iff (!rst_n)
    pdm_tick |=> !pdm_tick);

endmodule

/* verilog/mic_ctrl.sv */
`timescale 1ns/100ps
`include "audio_config.svh"

module mic_ctrl import audio_pkg::*; (
  input  logic           clk_m,
  input  logic           rst_n,
  input  logic           enable,
  input  src_mode_t      mode,      // requested source
  input  logic [2:0]     vol,       // requested volume
  input  logic           pdm_tick,
  input  logic           pcm_valid, // final stage strobe at each sample boundary
  audio_ctrl_if.ctrl     ctrl,
  output logic           active,    // runs the mic clock
  output logic           busy
);

  localparam int WARMUP = `AUDIO_WARMUP_TICKS;
  localparam int WARM_W = $clog2(WARMUP + 1);

  ctrl_state_t       state;
  ctrl_state_t       state_nxt;
  logic [WARM_W-1:0] warm_cnt; // ticks seen in warm-up
  logic              was_run;  // run in the previous cycle
  logic              latch;    // copy mode and volume this cycle

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:   if (enable) state_nxt = st_warmup;
      st_warmup: if (pdm_tick && warm_cnt == WARM_W'(WARMUP - 1)) state_nxt = st_run;
      st_run:    state_nxt = st_run;
      default:   state_nxt = st_idle; // unused encoding
    endcase
    if (!enable) begin
      state_nxt = st_idle; // disable wins from any state
    end
  end

  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      warm_cnt <= '0;
      was_run  <= 1'b0;
    end else begin
      state   <= state_nxt;
      was_run <= (state == st_run);
      if (state != st_warmup) begin
        warm_cnt <= '0;
      end else if (pdm_tick) begin
        warm_cnt <= warm_cnt + 1'b1;
      end
    end
  end

  // first run cycle and every finished pcm sample after it
  assign latch = (state == st_run) && (!was_run || pcm_valid);

  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      ctrl.src_mode <= src_mute;
      ctrl.vol      <= 3'd0;
    end else if (latch) begin
      ctrl.src_mode <= mode;
      ctrl.vol      <= vol;
    end
  end

  assign ctrl.clear = (state == st_warmup);
  assign ctrl.run   = (state == st_run);
  assign active     = (state != st_idle);
  assign busy       = active;

  // run only ever starts straight out of a cleared warm-up
  a_run_after_clear : assert property (@(posedge clk_m) disable iff (!rst_n)
    $rose(ctrl.run) |-> $past(ctrl.clear));

endmodule

/* verilog/fir_decimator.sv */
`timescale 1ns/100ps

// 4-tap moving average keeping one result every DECIM inputs
module fir_decimator import audio_pkg::*; #(
  parameter int DECIM = 2
) (
  input  logic        clk_m,
  input  logic        rst_n,
  audio_ctrl_if.dp    ctrl,
  input  logic        in_valid,
  input  pcm_t        in_sample,
  output logic        out_valid,
  output pcm_t        out_sample
);

  localparam int CNT_W = (DECIM > 1) ? $clog2(DECIM) : 1;

  pcm_t               hist [3];  // three previous inputs with the newest first
  logic [CNT_W-1:0]   phase;     // inputs seen in the current group
  logic               last;      // this input completes the group
  logic signed [17:0] sum;       // new sample plus history with two guard bits

  assign last = (phase == CNT_W'(DECIM - 1));
  assign sum  = in_sample + hist[0] + hist[1] + hist[2];

  // history zeroed while cleared
  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      hist[0] <= '0;
      hist[1] <= '0;
      hist[2] <= '0;
    end else if (ctrl.clear) begin
      hist[0] <= '0;
      hist[1] <= '0;
      hist[2] <= '0;
    end else if (in_valid) begin
      hist[2] <= hist[1];
      hist[1] <= hist[0];
      hist[0] <= in_sample;
    end
  end

  // input counter modulo DECIM
  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (ctrl.clear) begin
      phase <= '0;
    end else if (in_valid) begin
      phase <= last ? '0 : phase + 1'b1;
    end
  end

  // strobe one cycle after the completing input
  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid && last && !ctrl.clear;
    end
  end

  // output sample held between strobes
  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      out_sample <= '0;
    end else if (ctrl.clear) begin
      out_sample <= '0;
    end else if (in_valid && last) begin
      out_sample <= sum[17:2]; // arithmetic divide by 4
    end
  end

  // sample only moves together with its strobe or after a clear
  a_sample_held : assert property (@(posedge clk_m) disable iff (!rst_n)
    !out_valid && !$past(ctrl.clear) |-> $stable(out_sample));

endmodule

/* verilog/tone_gen.sv */
`timescale 1ns/100ps
`include "audio_config.svh"

module tone_gen import audio_pkg::*; (
  input  logic     clk_m,
  input  logic     rst_n,
  audio_ctrl_if.dp ctrl,
  input  logic     step,  // one output sample done
  output level_t   tone
);

  logic [7:0] phase;
  logic [6:0] fold; // triangle magnitude 0..127

  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (ctrl.clear) begin
      phase <= '0; // restart the wave from the bottom
    end else if (step) begin
      phase <= phase + `AUDIO_TONE_STEP; // wraps mod 256
    end
  end

  // falling half mirrors the rising half
  assign fold = phase[7] ? ~phase[6:0] : phase[6:0];

  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      tone <= '0;
    end else begin
      tone <= level_t'({1'b0, fold}) - 8'sd64; // center around zero
    end
  end

endmodule

/* verilog/pdm_modulator.sv */
`timescale 1ns/100ps

module pdm_modulator import audio_pkg::*; (
  input  logic     clk_m,
  input  logic     rst_n,
  audio_ctrl_if.dp ctrl,
  input  logic     pdm_tick,
  input  logic     mic_bit,
  input  pcm_t     pcm,
  input  level_t   tone,
  output logic     spk
);

  logic       mic_q;  // mic bit from the last tick
  level_t     level;  // selected source
  level_t     scaled; // after volume
  logic [2:0] shift;
  logic [7:0] acc;    // sigma-delta integrator
  logic [8:0] acc_sum;

  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      mic_q <= 1'b0;
    end else if (pdm_tick) begin
      mic_q <= mic_bit;
    end
  end

  always_comb begin
    case (ctrl.src_mode)
      src_mic_pcm: level = pcm[7:0];  // low byte only
      src_tone:    level = tone;
      src_mic_raw: level = mic_q ? 8'sd64 : -8'sd64;
      default:     level = '0;        // mute
    endcase
  end

  assign shift  = 3'd7 - ctrl.vol;
  assign scaled = level >>> shift;

  // offset binary input, carry out is the density bit
  assign acc_sum = {1'b0, acc} + {1'b0, ~scaled[7], scaled[6:0]};

  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
      spk <= 1'b0;
    end else if (!ctrl.run) begin
      acc <= '0;   // silent outside run
      spk <= 1'b0;
    end else if (pdm_tick) begin
      acc <= acc_sum[7:0];
      spk <= acc_sum[8];
    end
  end

endmodule

/* verilog/pdm_audio_top.sv */
`timescale 1ns/100ps
`include "audio_config.svh"

module pdm_audio_top import audio_pkg::*; (
  input  logic       clk_m,
  input  logic       rst_n,
  input  logic       enable,
  input  src_mode_t  mode,
  input  logic [2:0] vol,
  input  logic       mic_data,
  output logic       mic_clk,
  output pcm_t       pcm_out,
  output logic       pcm_valid,
  output logic       spk,
  output logic       busy
);

  audio_ctrl_if u_ctrl_if ();

  logic   active;
  logic   pdm_tick;
  pcm_t   s1_in;     // mic bit as +/-64
  logic   s1_valid;
  pcm_t   s1_out;
  logic   s2_valid;
  pcm_t   s2_out;
  level_t tone;

  assign s1_in = mic_data ? pdm_one_level : -pdm_one_level; // sampled in the tick cycle

  pdm_clock_gen u_pdm_clock_gen (
    .clk_m    (clk_m),
    .rst_n    (rst_n),
    .active   (active),
    .mic_clk  (mic_clk),
    .pdm_tick (pdm_tick)
  );

  mic_ctrl u_mic_ctrl (
    .clk_m     (clk_m),
    .rst_n     (rst_n),
    .enable    (enable),
    .mode      (mode),
    .vol       (vol),
    .pdm_tick  (pdm_tick),
    .pcm_valid (pcm_valid),
    .ctrl      (u_ctrl_if),
    .active    (active),
    .busy      (busy)
  );

  // decimation cascade, 16 ticks per pcm sample
  fir_decimator #(.DECIM(`AUDIO_DEC1)) u_fir_dec1 (
    .clk_m      (clk_m),
    .rst_n      (rst_n),
    .ctrl       (u_ctrl_if),
    .in_valid   (pdm_tick),
    .in_sample  (s1_in),
    .out_valid  (s1_valid),
    .out_sample (s1_out)
  );

  fir_decimator #(.DECIM(`AUDIO_DEC2)) u_fir_dec2 (
    .clk_m      (clk_m),
    .rst_n      (rst_n),
    .ctrl       (u_ctrl_if),
    .in_valid   (s1_valid),
    .in_sample  (s1_out),
    .out_valid  (s2_valid),
    .out_sample (s2_out)
  );

  fir_decimator #(.DECIM(`AUDIO_DEC3)) u_fir_dec3 (
    .clk_m      (clk_m),
    .rst_n      (rst_n),
    .ctrl       (u_ctrl_if),
    .in_valid   (s2_valid),
    .in_sample  (s2_out),
    .out_valid  (pcm_valid),
    .out_sample (pcm_out)     // held between strobes
  );

  tone_gen u_tone_gen (
    .clk_m (clk_m),
    .rst_n (rst_n),
    .ctrl  (u_ctrl_if),
    .step  (pcm_valid),
    .tone  (tone)
  );

  pdm_modulator u_pdm_modulator (
    .clk_m    (clk_m),
    .rst_n    (rst_n),
    .ctrl     (u_ctrl_if),
    .pdm_tick (pdm_tick),
    .mic_bit  (mic_data),
    .pcm      (pcm_out),
    .tone     (tone),
    .spk      (spk)
  );

endmodule

/* tb/pdm_audio_model.sv */
`timescale 1ns/100ps
`include "audio_config.svh"

// reference for the decimation cascade, the tone and the sigma-delta output
module pdm_audio_model import audio_pkg::*; ();

  int         hist [3][3]; // per stage, newest first
  int         count [3];   // inputs seen in the current group
  int         decim [3];
  int         pcm_held;    // last cascade output, like the held pcm_out
  logic [7:0] phase;       // tone phase
  int         acc;         // integrator 0..255
  logic       last_bit;    // mic bit of the previous tick, kept across sessions
  src_mode_t  mode_q;      // latched source
  logic [2:0] vol_q;       // latched volume

  // filters, tone and integrator start from zero after warm-up
  task automatic restart();
    for (int s = 0; s < 3; s++) begin
      hist[s][0] = 0;
      hist[s][1] = 0;
      hist[s][2] = 0;
      count[s]   = 0;
    end
    pcm_held = 0;
    phase    = 8'd0;
    acc      = 0;
  endtask

  task automatic latch(input src_mode_t m, input logic [2:0] v);
    mode_q = m;
    vol_q  = v;
  endtask

  // triangle, -64 at phase 0, +63 at the top
  function automatic int tone_level(input logic [7:0] p);
    int mag;
    mag = p[7] ? 127 - int'(p[6:0]) : int'(p[6:0]);
    return mag - 64;
  endfunction

  // one input into stage s, moving average by 4 and keep every decim-th
  task automatic filter(input int s, input int x, output bit done, output int y);
    int sum;
    sum = x + hist[s][0] + hist[s][1] + hist[s][2];
    hist[s][2] = hist[s][1];
    hist[s][1] = hist[s][0];
    hist[s][0] = x;
    count[s]++;
    done = (count[s] == decim[s]);
    if (done) count[s] = 0;
    y = sum >>> 2; // floor division by 4
  endtask

  // one pdm tick; live means the data path is in run
  task automatic tick(input logic mic, input bit live, output logic spk_exp,
                      output bit ready, output int pcm_exp);
    int                level;
    int                scaled;
    int                sum;
    bit                d1;
    bit                d2;
    int                y1;
    int                y2;
    logic signed [7:0] low;
    spk_exp = 1'b0;
    ready   = 1'b0;
    pcm_exp = 0;
    if (live) begin
      low = pcm_held[7:0]; // playback sees the low byte only
      case (mode_q)
        src_mic_pcm: level = low;
        src_tone:    level = tone_level(phase);
        src_mic_raw: level = last_bit ? 64 : -64;
        default:     level = 0;
      endcase
      scaled  = level >>> (7 - vol_q);
      sum     = acc + scaled + 128; // offset binary
      spk_exp = (sum >= 256);       // carry is the density bit
      acc     = sum % 256;
      filter(0, mic ? 64 : -64, d1, y1);
      if (d1) filter(1, y1, d2, y2);
      if (d1 && d2) filter(2, y2, ready, pcm_exp);
      if (ready) begin
        pcm_held = pcm_exp;
        phase    = phase + `AUDIO_TONE_STEP; // tone steps once per sample
      end
    end
    last_bit = mic;
  endtask

  initial begin
    decim[0] = `AUDIO_DEC1;
    decim[1] = `AUDIO_DEC2;
    decim[2] = `AUDIO_DEC3;
    last_bit = 1'b0;
    mode_q   = src_mute;
    vol_q    = 3'd0;
    restart();
  end

endmodule

/* tb/tb_pdm_audio.sv */
`timescale 1ns/100ps
`include "audio_config.svh"

module tb_pdm_audio import audio_pkg::*; ();

  logic       clk_m = 1'b0;
  logic       rst_n;
  logic       enable;
  src_mode_t  mode;
  logic [2:0] vol;
  logic       mic_data;
  logic       mic_clk;
  pcm_t       pcm_out;
  logic       pcm_valid;
  logic       spk;
  logic       busy;

  integer seed;
  int     mic_rnd;
  int     pcm_queue [$];     // cascade outputs not yet seen on pcm_valid
  int     pcm_count = 0;
  int     ticks = 0;         // mic_clk rises since enable
  int     last_pcm_tick = 0;
  int     since_rise = 0;    // cycles since the last mic_clk rise
  bit     have_rise = 1'b0;
  bit     running = 1'b0;    // session live, tick tracking on
  logic   en_seen = 1'b0;    // enable at the previous negedge
  logic   busy_seen = 1'b0;
  logic   clk_seen = 1'b0;
  logic   mic_seen = 1'b0;   // mic_data in the previous cycle
  logic   spk_exp;
  bit     ready;
  int     pcm_exp;

  pdm_audio_top u_pdm_audio_top (
    .clk_m     (clk_m),
    .rst_n     (rst_n),
    .enable    (enable),
    .mode      (mode),
    .vol       (vol),
    .mic_data  (mic_data),
    .mic_clk   (mic_clk),
    .pcm_out   (pcm_out),
    .pcm_valid (pcm_valid),
    .spk       (spk),
    .busy      (busy)
  );

  pdm_audio_model u_model ();

  always #4 clk_m = ~clk_m; // 8 ns period

  always @(posedge clk_m) begin
    #1;
    mic_rnd  = $random(seed);
    mic_data = mic_rnd[0];
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error %s: expected %h, got %h", name, expected, actual);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1);
  endtask

  // everything sampled mid-cycle
  always @(negedge clk_m) begin
    if (rst_n) begin
      check_value("busy", busy, en_seen); // follows enable by one cycle
      if (!busy && !busy_seen) begin
        check_value("spk", spk, 0);
        check_value("mic_clk", mic_clk, 0);
      end
      if (running) begin
        since_rise++;
        if (mic_clk && !clk_seen) begin // tick was in the previous cycle
          if (have_rise) check_value("mic_clk_period", since_rise, 32);
          have_rise  = 1'b1;
          since_rise = 0;
          ticks++;
          u_model.tick(mic_seen, ticks > `AUDIO_WARMUP_TICKS, spk_exp, ready, pcm_exp);
          check_value("spk", spk, spk_exp);
          if (ready) pcm_queue.push_back(pcm_exp);
          if (ticks == `AUDIO_WARMUP_TICKS) u_model.latch(mode, vol); // first run cycle
        end else if (!mic_clk && clk_seen) begin
          check_value("mic_clk_high", since_rise, 16);
        end
      end
      if (pcm_valid) begin
        if (pcm_queue.size() == 0) begin
          fail_run("pcm_valid arrived while no sample was expected");
        end else begin
          check_value("pcm_out", pcm_out, pcm_queue.pop_front());
          check_value("pcm_period", ticks - last_pcm_tick, 16);
          last_pcm_tick = ticks;
          pcm_count++;
          u_model.latch(mode, vol); // sample boundary
        end
      end
      en_seen   = enable;
      busy_seen = busy;
      clk_seen  = mic_clk;
      mic_seen  = mic_data;
    end
  end

  // returns on a rising edge, ready for the drive delay
  task automatic wait_samples(input int n);
    int target;
    int limit;
    target = pcm_count + n;
    limit  = (n * 16 + 2 * `AUDIO_WARMUP_TICKS) * 32;
    for (int i = 0; i < limit && pcm_count < target; i++) @(posedge clk_m);
    if (pcm_count < target) fail_run("pcm_valid did not arrive in time");
  endtask

  task automatic run_session();
    int r;
    @(posedge clk_m);
    #1;
    u_model.restart();
    pcm_queue.delete();
    ticks         = 0;
    last_pcm_tick = `AUDIO_WARMUP_TICKS; // first sample 16 ticks into run
    have_rise     = 1'b0;
    since_rise    = 0;
    mode          = src_mic_pcm;
    vol           = 3'd7;
    enable        = 1'b1;
    running       = 1'b1;
    for (int i = 0; i < 8 && !busy; i++) @(negedge clk_m);
    if (!busy) fail_run("busy did not rise after enable");
    wait_samples(10);
    for (int k = 0; k < 16; k++) begin
      r = $random(seed);
      #1;
      mode = r[0] ? src_tone : src_mic_raw; // picked up at the next sample
      vol  = r[3:1];
      wait_samples(2);
    end
  endtask

  task automatic stop_session();
    wait_samples(1); // nothing left in flight right after a sample
    #1;
    running = 1'b0;
    enable  = 1'b0;
    for (int i = 0; i < 8 && busy; i++) @(negedge clk_m);
    if (busy) fail_run("busy stayed high after enable dropped");
    repeat (100) @(posedge clk_m); // monitor watches the quiet outputs
  endtask

  initial begin
    seed     = 98;
    rst_n    = 1'b0;
    enable   = 1'b0;
    mode     = src_mic_pcm;
    vol      = 3'd7;
    mic_data = 1'b0;
    repeat (3) @(posedge clk_m);
    #1 rst_n = 1'b1;
    repeat (100) begin
      @(negedge clk_m);
      check_value("mic_clk", mic_clk, 0);
      check_value("pcm_valid", pcm_valid, 0);
      check_value("spk", spk, 0);
      check_value("busy", busy, 0);
    end
    run_session();
    stop_session();
    run_session(); // restart from cleared filters
    stop_session();
    $display("** PASS **");
    $finish;
  end

endmodule

/* tb.f */
+incdir+verilog
verilog/audio_pkg.sv
verilog/audio_ctrl_if.sv
verilog/pdm_clock_gen.sv
verilog/mic_ctrl.sv
verilog/fir_decimator.sv
verilog/tone_gen.sv
verilog/pdm_modulator.sv
verilog/pdm_audio_top.sv
tb/pdm_audio_model.sv
tb/tb_pdm_audio.sv
